// File: design/turfio_cmd_pkg.sv
package turfio_cmd_pkg;

    // Command word from the TURF
    localparam int CMD_W       = 32;
    // Opcode sits in the top bits of the word
    localparam int OPC_W       = 3;
    // Trigger time rides in the low bits
    localparam int TRIG_TIME_W = 15;

    typedef enum logic [OPC_W-1:0] {
        CMD_NOP   = 3'd0,
        CMD_SYNC  = 3'd1,
        CMD_RESET = 3'd2,
        CMD_STOP  = 3'd3,
        CMD_PPS   = 3'd4,
        CMD_TRIG  = 3'd5
    } cmd_opcode_t;

    // Run timebase
    localparam int COUNT_W       = 48;
    localparam int CLK_OFFSET_W  = 32;
    localparam int SYNC_PERIOD   = 16;
    localparam int SYNC_PHASE_W  = 4;
    localparam int STAMP_COUNT_W = 16;

    // Upper counter bits joined with the TURF trigger time
    typedef struct packed {
        logic [COUNT_W-TRIG_TIME_W-1:0] count_hi;
        logic [TRIG_TIME_W-1:0]         trig_time;
    } trig_stamp_t;

endpackage

// File: design/turfio_reg_pkg.sv
package turfio_reg_pkg;

    // APB bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, byte addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [APB_ADDR_W-1:0] REG_ID         = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_VERSION    = 8'h04;
    // Sync offset in bits 3..0
    localparam logic [APB_ADDR_W-1:0] REG_CTRL       = 8'h08;
    // Counter load value on run reset
    localparam logic [APB_ADDR_W-1:0] REG_CLK_OFFSET = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_COUNT_LO   = 8'h10;
    // Top 16 counter bits
    localparam logic [APB_ADDR_W-1:0] REG_COUNT_HI   = 8'h14;
    localparam logic [APB_ADDR_W-1:0] REG_PPS_LO     = 8'h18;
    localparam logic [APB_ADDR_W-1:0] REG_TRIG_LO    = 8'h1C;
    // PPS count low half, trigger count high half
    localparam logic [APB_ADDR_W-1:0] REG_STATUS     = 8'h20;

    // Identity
    localparam logic [31:0] DEVICE_ID = "TFIO";

    // Version fields, major.minor.rev
    localparam logic [3:0]  VER_MAJOR  = 4'd0;
    localparam logic [3:0]  VER_MINOR  = 4'd2;
    localparam logic [7:0]  VER_REV    = 8'd3;
    localparam logic [15:0] FW_VERSION = {VER_MAJOR, VER_MINOR, VER_REV};

endpackage

// File: design/turfio_run_if.sv
`timescale 1ns/1ps

// Decoded run commands, one-cycle strobes
interface turfio_run_if;

    logic                                   sync_req;
    logic                                   run_reset;
    logic                                   run_stop;
    logic                                   pps;
    logic                                   trig;
    // Valid alongside trig
    logic [turfio_cmd_pkg::TRIG_TIME_W-1:0] trig_time;

    // Command decoder drives everything
    modport decoder (
        output sync_req,
        output run_reset,
        output run_stop,
        output pps,
        output trig,
        output trig_time
    );

    // Counter and sync phase logic
    modport timebase (
        input sync_req,
        input run_reset,
        input run_stop
    );

    // Event stamping side
    modport stamp (
        input pps,
        input trig,
        input trig_time
    );

endinterface

// File: design/turf_cmd_decoder.sv
`timescale 1ns/1ps

module turf_cmd_decoder (
    input  logic                             init_clk,
    input  logic                             rst_i,
    input  logic [turfio_cmd_pkg::CMD_W-1:0] cmd_i,
    input  logic                             cmd_valid_i,
    turfio_run_if.decoder                    run
);

    // Registered opcode and its qualifier
    turfio_cmd_pkg::cmd_opcode_t            opc_q;
    logic                                   opc_valid_q;
    // Trigger time field, payload only
    logic [turfio_cmd_pkg::TRIG_TIME_W-1:0] trig_time_q;

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            opc_valid_q <= 1'b0;
            opc_q       <= turfio_cmd_pkg::CMD_NOP;
        end else begin
            opc_valid_q <= cmd_valid_i;
            // Top three bits of the word
            opc_q       <= turfio_cmd_pkg::cmd_opcode_t'(
                               cmd_i[turfio_cmd_pkg::CMD_W-1 -: turfio_cmd_pkg::OPC_W]);
        end
    end

    always_ff @(posedge init_clk) begin
        if (cmd_valid_i) begin
            trig_time_q <= cmd_i[turfio_cmd_pkg::TRIG_TIME_W-1:0];
        end
    end

    // One strobe per known opcode, unknown codes fall through
    always_comb begin
        run.sync_req  = 1'b0;
        run.run_reset = 1'b0;
        run.run_stop  = 1'b0;
        run.pps       = 1'b0;
        run.trig      = 1'b0;
        if (opc_valid_q) begin
            case (opc_q)
                turfio_cmd_pkg::CMD_SYNC:  run.sync_req  = 1'b1;
                turfio_cmd_pkg::CMD_RESET: run.run_reset = 1'b1;
                turfio_cmd_pkg::CMD_STOP:  run.run_stop  = 1'b1;
                turfio_cmd_pkg::CMD_PPS:   run.pps       = 1'b1;
                turfio_cmd_pkg::CMD_TRIG:  run.trig      = 1'b1;
                default: ;
            endcase
        end
    end

    assign run.trig_time = trig_time_q;

endmodule

// File: design/run_timebase.sv
`timescale 1ns/1ps

module run_timebase (
    input  logic                                    init_clk,
    input  logic                                    rst_i,
    turfio_run_if.timebase                          run,
    input  logic [turfio_cmd_pkg::CLK_OFFSET_W-1:0] clk_offset_i,
    input  logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0] sync_offset_i,
    output logic [turfio_cmd_pkg::COUNT_W-1:0]      count_o,
    output logic                                    running_o,
    output logic                                    sync_o
);

    // Run counter and state
    logic [turfio_cmd_pkg::COUNT_W-1:0]      count_q;
    logic                                    running_q;
    // Position inside the 16-cycle sync period
    logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0] phase_q;

    ////////////////////////////////////////////////////////////////////////////
    // Run counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            count_q   <= '0;
            running_q <= 1'b0;
        end else if (run.run_reset) begin
            // Start from the programmed offset, zero-extended
            count_q   <= {{(turfio_cmd_pkg::COUNT_W - turfio_cmd_pkg::CLK_OFFSET_W){1'b0}},
                          clk_offset_i};
            running_q <= 1'b1;
        end else if (run.run_stop) begin
            // Counter freezes where it is
            running_q <= 1'b0;
        end else if (running_q) begin
            count_q   <= count_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sync phase
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            phase_q <= '0;
        end else if (run.sync_req) begin
            // Realign to the requested offset
            phase_q <= sync_offset_i;
        end else if (phase_q == turfio_cmd_pkg::SYNC_PERIOD - 1) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    assign count_o   = count_q;
    assign running_o = running_q;
    // First cycle of the period
    assign sync_o    = (phase_q == '0);

endmodule

// File: design/event_stamp.sv
`timescale 1ns/1ps

module event_stamp #(
    parameter type payload_t = logic [47:0]
) (
    input  logic                                     init_clk,
    input  logic                                     rst_i,
    input  logic                                     capture_i,
    input  payload_t                                 payload_i,
    output payload_t                                 stamp_o,
    output logic                                     stamp_valid_o,
    output logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] count_o
);

    // Last captured payload
    payload_t                                 stamp_q;
    logic                                     valid_q;
    // Number of captures, wraps freely
    logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] count_q;

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            stamp_q <= '0;
            valid_q <= 1'b0;
            count_q <= '0;
        end else begin
            // Valid follows capture by one cycle
            valid_q <= capture_i;
            if (capture_i) begin
                stamp_q <= payload_i;
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign stamp_o       = stamp_q;
    assign stamp_valid_o = valid_q;
    assign count_o       = count_q;

endmodule

// File: design/timing_apb_regs.sv
`timescale 1ns/1ps

module timing_apb_regs (
    input  logic                                     init_clk,
    input  logic                                     rst_i,
    input  logic                                     psel_i,
    input  logic                                     penable_i,
    input  logic                                     pwrite_i,
    input  logic [turfio_reg_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  logic [turfio_reg_pkg::APB_DATA_W-1:0]    pwdata_i,
    output logic [turfio_reg_pkg::APB_DATA_W-1:0]    prdata_o,
    output logic                                     pready_o,
    output logic                                     pslverr_o,
    input  logic [turfio_cmd_pkg::COUNT_W-1:0]       count_i,
    input  logic [turfio_cmd_pkg::COUNT_W-1:0]       pps_stamp_i,
    input  turfio_cmd_pkg::trig_stamp_t              trig_stamp_i,
    input  logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] pps_count_i,
    input  logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] trig_count_i,
    output logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0]  sync_offset_o,
    output logic [turfio_cmd_pkg::CLK_OFFSET_W-1:0]  clk_offset_o
);

    // Writable offsets
    logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0] sync_offset_q;
    logic [turfio_cmd_pkg::CLK_OFFSET_W-1:0] clk_offset_q;
    // Address decode results
    logic [turfio_reg_pkg::APB_DATA_W-1:0]   rdata;
    logic                                    addr_ok;
    logic                                    access;

    // Access phase, no wait states
    assign access = psel_i & penable_i;

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and map check
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (paddr_i)
            turfio_reg_pkg::REG_ID:         rdata = turfio_reg_pkg::DEVICE_ID;
            turfio_reg_pkg::REG_VERSION:    rdata = {16'h0000, turfio_reg_pkg::FW_VERSION};
            turfio_reg_pkg::REG_CTRL:       rdata = {28'h0, sync_offset_q};
            turfio_reg_pkg::REG_CLK_OFFSET: rdata = clk_offset_q;
            turfio_reg_pkg::REG_COUNT_LO:   rdata = count_i[31:0];
            // Upper 16 counter bits
            turfio_reg_pkg::REG_COUNT_HI:   rdata = {16'h0000, count_i[47:32]};
            turfio_reg_pkg::REG_PPS_LO:     rdata = pps_stamp_i[31:0];
            turfio_reg_pkg::REG_TRIG_LO:    rdata = trig_stamp_i[31:0];
            turfio_reg_pkg::REG_STATUS:     rdata = {trig_count_i, pps_count_i};
            default:                        addr_ok = 1'b0;
        endcase
    end

    // Writes land at the end of the access phase
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            sync_offset_q <= '0;
            clk_offset_q  <= '0;
        end else if (access && pwrite_i) begin
            case (paddr_i)
                turfio_reg_pkg::REG_CTRL:       sync_offset_q <= pwdata_i[3:0];
                turfio_reg_pkg::REG_CLK_OFFSET: clk_offset_q  <= pwdata_i;
                // Read-only or unmapped, dropped
                default: ;
            endcase
        end
    end

    assign prdata_o      = rdata;
    assign pready_o      = 1'b1;
    assign pslverr_o     = access & ~addr_ok;
    assign sync_offset_o = sync_offset_q;
    assign clk_offset_o  = clk_offset_q;

endmodule

// File: design/turfio_timing_top.sv
`timescale 1ns/1ps

module turfio_timing_top (
    input  logic                                  init_clk,
    input  logic                                  rst_i,
    // TURF command path
    input  logic [turfio_cmd_pkg::CMD_W-1:0]      cmd_i,
    input  logic                                  cmd_valid_i,
    // APB slave
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [turfio_reg_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [turfio_reg_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [turfio_reg_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,
    // Timing outputs
    output logic [turfio_cmd_pkg::COUNT_W-1:0]    count_o,
    output logic                                  running_o,
    output logic                                  sync_o,
    output logic                                  pps_valid_o,
    output logic                                  trig_valid_o
);

    logic [turfio_cmd_pkg::COUNT_W-1:0]       pps_stamp;
    turfio_cmd_pkg::trig_stamp_t              trig_stamp;
    turfio_cmd_pkg::trig_stamp_t              trig_payload;
    logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] pps_count;
    logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] trig_count;
    logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0]  sync_offset;
    logic [turfio_cmd_pkg::CLK_OFFSET_W-1:0]  clk_offset;

    turfio_run_if run_bus ();

    turf_cmd_decoder u_decoder (
        .init_clk(init_clk), .rst_i(rst_i), .cmd_i(cmd_i), .cmd_valid_i(cmd_valid_i),
        .run(run_bus.decoder)
    );

    run_timebase u_timebase (
        .init_clk(init_clk), .rst_i(rst_i), .run(run_bus.timebase),
        .clk_offset_i(clk_offset), .sync_offset_i(sync_offset),
        .count_o(count_o), .running_o(running_o), .sync_o(sync_o)
    );

    // Trigger payload, counter top bits with the TURF trigger time
    assign trig_payload.count_hi  = count_o[turfio_cmd_pkg::COUNT_W-1:turfio_cmd_pkg::TRIG_TIME_W];
    assign trig_payload.trig_time = run_bus.trig_time;

    event_stamp #(.payload_t(logic [turfio_cmd_pkg::COUNT_W-1:0])) u_pps_stamp (
        .init_clk(init_clk), .rst_i(rst_i), .capture_i(run_bus.pps), .payload_i(count_o),
        .stamp_o(pps_stamp), .stamp_valid_o(pps_valid_o), .count_o(pps_count)
    );

    event_stamp #(.payload_t(turfio_cmd_pkg::trig_stamp_t)) u_trig_stamp (
        .init_clk(init_clk), .rst_i(rst_i), .capture_i(run_bus.trig), .payload_i(trig_payload),
        .stamp_o(trig_stamp), .stamp_valid_o(trig_valid_o), .count_o(trig_count)
    );

    timing_apb_regs u_regs (
        .init_clk(init_clk), .rst_i(rst_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .count_i(count_o), .pps_stamp_i(pps_stamp), .trig_stamp_i(trig_stamp),
        .pps_count_i(pps_count), .trig_count_i(trig_count),
        .sync_offset_o(sync_offset), .clk_offset_o(clk_offset)
    );

endmodule

// File: testbench/tb_turfio_timing.sv
`timescale 1ns/1ps

module tb_turfio_timing;

    // Run length and watchdog
    localparam int STIM_CYCLES = 400;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

    // Cycle model of the timing path
    typedef struct packed {
        logic                                     dec_valid;
        logic [turfio_cmd_pkg::OPC_W-1:0]         dec_opc;
        logic [turfio_cmd_pkg::TRIG_TIME_W-1:0]   dec_time;
        logic [turfio_cmd_pkg::COUNT_W-1:0]       count;
        logic                                     running;
        logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0]  phase;
        logic [turfio_cmd_pkg::SYNC_PHASE_W-1:0]  sync_off;
        logic [turfio_cmd_pkg::CLK_OFFSET_W-1:0]  clk_off;
        logic [turfio_cmd_pkg::COUNT_W-1:0]       pps_stamp;
        turfio_cmd_pkg::trig_stamp_t              trig_stamp;
        logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] pps_cnt;
        logic [turfio_cmd_pkg::STAMP_COUNT_W-1:0] trig_cnt;
        logic                                     pps_v;
        logic                                     trig_v;
    } model_t;

    logic                                  init_clk;
    logic                                  rst_i;
    logic [turfio_cmd_pkg::CMD_W-1:0]      cmd_i;
    logic                                  cmd_valid_i;
    logic                                  psel_i;
    logic                                  penable_i;
    logic                                  pwrite_i;
    logic [turfio_reg_pkg::APB_ADDR_W-1:0] paddr_i;
    logic [turfio_reg_pkg::APB_DATA_W-1:0] pwdata_i;
    logic [turfio_reg_pkg::APB_DATA_W-1:0] prdata_o;
    logic                                  pready_o;
    logic                                  pslverr_o;
    logic [turfio_cmd_pkg::COUNT_W-1:0]    count_o;
    logic                                  running_o;
    logic                                  sync_o;
    logic                                  pps_valid_o;
    logic                                  trig_valid_o;

    model_t                                m;
    model_t                                snap;
    logic [turfio_reg_pkg::APB_DATA_W-1:0] rd_data;
    logic                                  rd_err;
    logic                                  wr_err;
    logic [31:0]                           rnd;
    integer                                seed;
    int                                    errors = 0;
    int                                    checks = 0;
    int                                    cycles = 0;

    turfio_timing_top UUT (
        .init_clk(init_clk), .rst_i(rst_i), .cmd_i(cmd_i), .cmd_valid_i(cmd_valid_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i), .paddr_i(paddr_i),
        .pwdata_i(pwdata_i), .prdata_o(prdata_o), .pready_o(pready_o),
        .pslverr_o(pslverr_o), .count_o(count_o), .running_o(running_o), .sync_o(sync_o),
        .pps_valid_o(pps_valid_o), .trig_valid_o(trig_valid_o)
    );

    // 8 ns clock
    initial begin
        init_clk = 1'b0;
        forever #4 init_clk = ~init_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, one step per rising edge
    ////////////////////////////////////////////////////////////////////////////

    function automatic model_t step_model(input model_t s,
                                          input logic [turfio_cmd_pkg::CMD_W-1:0] cmd,
                                          input logic cmd_valid, input logic wr,
                                          input logic [turfio_reg_pkg::APB_ADDR_W-1:0] addr,
                                          input logic [turfio_reg_pkg::APB_DATA_W-1:0] wdata);
        model_t n;
        logic   is_sync;
        logic   is_reset;
        logic   is_stop;
        logic   is_pps;
        logic   is_trig;
        n        = s;
        // Strobes come from the word registered one edge earlier
        is_sync  = s.dec_valid && s.dec_opc == turfio_cmd_pkg::CMD_SYNC;
        is_reset = s.dec_valid && s.dec_opc == turfio_cmd_pkg::CMD_RESET;
        is_stop  = s.dec_valid && s.dec_opc == turfio_cmd_pkg::CMD_STOP;
        is_pps   = s.dec_valid && s.dec_opc == turfio_cmd_pkg::CMD_PPS;
        is_trig  = s.dec_valid && s.dec_opc == turfio_cmd_pkg::CMD_TRIG;
        n.dec_valid = cmd_valid;
        n.dec_opc   = cmd[turfio_cmd_pkg::CMD_W-1 -: turfio_cmd_pkg::OPC_W];
        if (cmd_valid) begin
            n.dec_time = cmd[turfio_cmd_pkg::TRIG_TIME_W-1:0];
        end
        // Reset beats stop and stop beats counting
        if (is_reset) begin
            n.count   = {16'h0000, s.clk_off};
            n.running = 1'b1;
        end else if (is_stop) begin
            n.running = 1'b0;
        end else if (s.running) begin
            n.count = s.count + 48'd1;
        end
        // 4-bit phase wraps at 16 by itself
        n.phase  = is_sync ? s.sync_off : s.phase + 4'd1;
        n.pps_v  = is_pps;
        n.trig_v = is_trig;
        // Stamps see the counter before this edge
        if (is_pps) begin
            n.pps_stamp = s.count;
            n.pps_cnt   = s.pps_cnt + 16'd1;
        end
        if (is_trig) begin
            n.trig_stamp = {s.count[turfio_cmd_pkg::COUNT_W-1:turfio_cmd_pkg::TRIG_TIME_W],
                            s.dec_time};
            n.trig_cnt   = s.trig_cnt + 16'd1;
        end
        if (wr && addr == turfio_reg_pkg::REG_CTRL) begin
            n.sync_off = wdata[3:0];
        end
        if (wr && addr == turfio_reg_pkg::REG_CLK_OFFSET) begin
            n.clk_off = wdata;
        end
        return n;
    endfunction

    always @(posedge init_clk) begin
        if (rst_i) begin
            m = '0;
        end else begin
            m = step_model(m, cmd_i, cmd_valid_i, psel_i & penable_i & pwrite_i,
                           paddr_i, pwdata_i);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_count(input string what,
                               input logic [turfio_cmd_pkg::COUNT_W-1:0] got,
                               input logic [turfio_cmd_pkg::COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_stamp(input string what, input turfio_cmd_pkg::trig_stamp_t got,
                               input turfio_cmd_pkg::trig_stamp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what,
                              input logic [turfio_reg_pkg::APB_DATA_W-1:0] got,
                              input logic [turfio_reg_pkg::APB_DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge init_clk) begin
        if (!rst_i) begin
            check_count("count_o", count_o, m.count);
            check_flag("running_o", running_o, m.running);
            check_flag("sync_o", sync_o, m.phase == 4'd0);
            check_flag("pps_valid_o", pps_valid_o, m.pps_v);
            check_flag("trig_valid_o", trig_valid_o, m.trig_v);
            // No error outside an access phase
            if (!(psel_i && penable_i)) begin
                check_flag("pslverr_o idle", pslverr_o, 1'b0);
            end
            if (m.pps_v) begin
                check_count("pps stamp", UUT.pps_stamp, m.pps_stamp);
            end
            if (m.trig_v) begin
                check_stamp("trig stamp", UUT.trig_stamp, m.trig_stamp);
            end
        end
    end

    // Watchdog
    always @(posedge init_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [turfio_cmd_pkg::CMD_W-1:0] make_cmd(
            input turfio_cmd_pkg::cmd_opcode_t opc,
            input logic [turfio_cmd_pkg::TRIG_TIME_W-1:0] t);
        return {opc, 14'h0000, t};
    endfunction

    task automatic drive_cmd(input logic [turfio_cmd_pkg::CMD_W-1:0] word, input logic valid);
        @(posedge init_clk);
        #1;
        cmd_i       = word;
        cmd_valid_i = valid;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge init_clk);
            #1;
            cmd_i       = '0;
            cmd_valid_i = 1'b0;
        end
    endtask

    // Returns the error flag seen during the access phase
    task automatic apb_write(input logic [turfio_reg_pkg::APB_ADDR_W-1:0] addr,
                             input logic [turfio_reg_pkg::APB_DATA_W-1:0] data,
                             output logic err);
        @(posedge init_clk);
        #1;
        psel_i    = 1'b1;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(posedge init_clk);
        #1;
        penable_i = 1'b1;
        @(negedge init_clk);
        err = pslverr_o;
        check_flag("pready_o", pready_o, 1'b1);
        @(posedge init_clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Returns the model state seen during the access phase
    task automatic apb_read(input logic [turfio_reg_pkg::APB_ADDR_W-1:0] addr,
                            output logic [turfio_reg_pkg::APB_DATA_W-1:0] data,
                            output logic err, output model_t seen);
        @(posedge init_clk);
        #1;
        psel_i    = 1'b1;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(posedge init_clk);
        #1;
        penable_i = 1'b1;
        @(negedge init_clk);
        data = prdata_o;
        err  = pslverr_o;
        seen = m;
        check_flag("pready_o", pready_o, 1'b1);
        @(posedge init_clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 50;
        rst_i       = 1'b1;
        cmd_i       = '0;
        cmd_valid_i = 1'b0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        repeat (8) @(posedge init_clk);
        #1;
        rst_i = 1'b0;

        // Identity, version, unmapped access
        apb_read(turfio_reg_pkg::REG_ID, rd_data, rd_err, snap);
        check_word("id", rd_data, turfio_reg_pkg::DEVICE_ID);
        check_flag("pslverr_o on id", rd_err, 1'b0);
        apb_read(turfio_reg_pkg::REG_VERSION, rd_data, rd_err, snap);
        check_word("version", rd_data, {16'h0000, turfio_reg_pkg::FW_VERSION});
        // Same low bits as the clock offset register
        apb_write(8'h4C, 32'hDEAD_BEEF, wr_err);
        check_flag("pslverr_o on unmapped write", wr_err, 1'b1);
        apb_read(8'h24, rd_data, rd_err, snap);
        check_flag("pslverr_o on unmapped", rd_err, 1'b1);
        apb_read(turfio_reg_pkg::REG_CLK_OFFSET, rd_data, rd_err, snap);
        check_word("clk offset after reset", rd_data, 32'h0);

        // Load, run across the 32-bit boundary, then stop
        apb_write(turfio_reg_pkg::REG_CLK_OFFSET, 32'hFFFF_FFE0, wr_err);
        check_flag("pslverr_o on clk offset write", wr_err, 1'b0);
        apb_read(turfio_reg_pkg::REG_CLK_OFFSET, rd_data, rd_err, snap);
        check_word("clk offset", rd_data, 32'hFFFF_FFE0);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_RESET, '0), 1'b1);
        idle(40);
        apb_read(turfio_reg_pkg::REG_COUNT_LO, rd_data, rd_err, snap);
        check_word("count lo", rd_data, snap.count[31:0]);
        apb_read(turfio_reg_pkg::REG_COUNT_HI, rd_data, rd_err, snap);
        check_word("count hi", rd_data, {16'h0000, snap.count[47:32]});
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_STOP, '0), 1'b1);
        idle(6);
        check_flag("running_o after stop", running_o, 1'b0);

        // Sync realignment
        apb_write(turfio_reg_pkg::REG_CTRL, 32'h0000_0005, wr_err);
        check_flag("pslverr_o on ctrl write", wr_err, 1'b0);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_SYNC, '0), 1'b1);
        idle(40);
        apb_read(turfio_reg_pkg::REG_CTRL, rd_data, rd_err, snap);
        check_word("sync offset", rd_data, 32'h0000_0005);

        // Back-to-back PPS and triggers
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_RESET, '0), 1'b1);
        idle(3);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_PPS, '0), 1'b1);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_TRIG, 15'h1234), 1'b1);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_TRIG, 15'h7ABC), 1'b1);
        drive_cmd(make_cmd(turfio_cmd_pkg::CMD_PPS, '0), 1'b1);
        idle(4);
        apb_read(turfio_reg_pkg::REG_PPS_LO, rd_data, rd_err, snap);
        check_word("pps lo", rd_data, snap.pps_stamp[31:0]);
        apb_read(turfio_reg_pkg::REG_TRIG_LO, rd_data, rd_err, snap);
        check_word("trig lo", rd_data, snap.trig_stamp[31:0]);
        apb_read(turfio_reg_pkg::REG_STATUS, rd_data, rd_err, snap);
        check_word("status", rd_data, {16'd2, 16'd2});

        // Unknown opcodes 6 and 7, or any word without valid
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                drive_cmd({2'b11, rnd[29:0]}, 1'b1);
            end else begin
                drive_cmd(rnd, 1'b0);
            end
        end
        idle(4);
        apb_read(turfio_reg_pkg::REG_STATUS, rd_data, rd_err, snap);
        check_word("status after noise", rd_data, {16'd2, 16'd2});

        idle(2);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
design/turfio_cmd_pkg.sv
design/turfio_reg_pkg.sv
design/turfio_run_if.sv
design/turf_cmd_decoder.sv
design/run_timebase.sv
design/event_stamp.sv
design/timing_apb_regs.sv
design/turfio_timing_top.sv
testbench/tb_turfio_timing.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_turfio_timing
FILELIST  = project.f
PASS_MSG  = *** PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf obj_dir
